//--- Bender.yml
package:
  name: cp0

sources:
  - files:
      - design/cp0RegPkg.sv
      - design/cp0ExcPkg.sv
      - design/cp0ExcCtrl.sv
      - design/cp0RegFile.sv
      - design/cp0Timer.sv
      - design/cp0IntrUnit.sv
      - design/cp0Top.sv
  - target: simulation
    files:
      - sim/cp0Top_checker.sv
      - sim/cp0Tb.sv

//--- design/cp0ExcCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module cp0ExcCtrl (
    input  logic                   clk,
    input  logic                   rst,
    input  cp0ExcPkg::excReport_t  excIn,
    input  cp0RegPkg::cp0Status_t  status,
    input  logic [31:0]            epc,
    input  logic [31:0]            eBase,
    input  logic                   bev,
    output cp0ExcPkg::excUpdate_t  excUpd,
    output logic                   dropWrite,
    output cp0ExcPkg::redirect_t   redirect
);

    logic        isEret;
    logic        taken;
    logic [4:0]  code;
    logic        addrErr;
    logic [31:0] vecBase;
    logic [31:0] target;

    assign isEret  = (excIn.kind == cp0ExcPkg::KIND_ERET);
    assign taken   = excIn.valid && !status.exl && !isEret; // Nested reports change nothing
    assign addrErr = (excIn.kind == cp0ExcPkg::KIND_ADEL) ||
                     (excIn.kind == cp0ExcPkg::KIND_ADES);

    always_comb begin
        case (excIn.kind)
            cp0ExcPkg::KIND_INT:  code = cp0ExcPkg::EXC_INT;
            cp0ExcPkg::KIND_ADEL: code = cp0ExcPkg::EXC_ADEL;
            cp0ExcPkg::KIND_ADES: code = cp0ExcPkg::EXC_ADES;
            cp0ExcPkg::KIND_RI:   code = cp0ExcPkg::EXC_RI;
            cp0ExcPkg::KIND_SYS:  code = cp0ExcPkg::EXC_SYS;
            cp0ExcPkg::KIND_BP:   code = cp0ExcPkg::EXC_BP;
            cp0ExcPkg::KIND_OV:   code = cp0ExcPkg::EXC_OV;
            default:              code = cp0ExcPkg::EXC_INT;
        endcase
    end

    always_comb begin
        excUpd.setExl       = taken;
        excUpd.clrExl       = excIn.valid && isEret;
        excUpd.loadBadVAddr = taken && addrErr;
        excUpd.bd           = excIn.delaySlot;
        excUpd.code         = code;
        excUpd.epc          = excIn.delaySlot ? (excIn.pc - 32'd4) : excIn.pc; // Point at branch
        excUpd.badAddr      = excIn.badAddr;
    end

    // An exception in the same cycle wins over a move-to-CP0
    assign dropWrite = excIn.valid;

    assign vecBase = bev ? cp0ExcPkg::BEV_BASE : eBase;
    assign target  = isEret ? epc : (vecBase + cp0ExcPkg::VEC_OFFSET);

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect.valid <= 1'b0;
        end else begin
            redirect.valid <= excIn.valid; // One-cycle pulse
        end
        if (excIn.valid) begin
            redirect.target <= target; // EPC sampled before its update
        end
    end

endmodule

`default_nettype wire

//--- design/cp0ExcPkg.sv
`default_nettype none

package cp0ExcPkg;

    typedef enum logic [2:0] {
        KIND_INT  = 3'd0,
        KIND_ADEL = 3'd1,
        KIND_ADES = 3'd2,
        KIND_RI   = 3'd3,
        KIND_SYS  = 3'd4,
        KIND_BP   = 3'd5,
        KIND_OV   = 3'd6,
        KIND_ERET = 3'd7
    } excKind_t;

    localparam logic [4:0] EXC_INT  = 5'h00;
    localparam logic [4:0] EXC_ADEL = 5'h04;
    localparam logic [4:0] EXC_ADES = 5'h05;
    localparam logic [4:0] EXC_SYS  = 5'h08;
    localparam logic [4:0] EXC_BP   = 5'h09;
    localparam logic [4:0] EXC_RI   = 5'h0A;
    localparam logic [4:0] EXC_OV   = 5'h0C;

    localparam logic [31:0] VEC_OFFSET = 32'h0000_0180;
    localparam logic [31:0] BEV_BASE   = 32'hBFC0_0200; // Boot vector base while BEV

    typedef struct packed {
        logic        valid;
        excKind_t    kind;
        logic [31:0] pc;
        logic        delaySlot;
        logic [31:0] badAddr;
    } excReport_t;

    typedef struct packed {
        logic        setExl;
        logic        clrExl;
        logic        loadBadVAddr;
        logic        bd;
        logic [4:0]  code;
        logic [31:0] epc;
        logic [31:0] badAddr;
    } excUpdate_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- design/cp0IntrUnit.sv
`timescale 1ns/100ps
`default_nettype none

module cp0IntrUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [5:0]             hwInt,
    input  logic [1:0]             swIp,
    input  logic                   timerHit,
    input  cp0RegPkg::cp0Status_t  status,
    output logic [7:0]             ipPending,
    output logic                   intReq
);

    logic [5:0] hwSync1;
    logic [5:0] hwSync2;
    logic [5:0] hwIp; // Mirrors Cause.IP7..2

    always_ff @(posedge clk) begin
        if (rst) begin
            hwSync1 <= '0;
            hwSync2 <= '0;
            hwIp    <= '0;
        end else begin
            hwSync1 <= hwInt;
            hwSync2 <= hwSync1;
            hwIp    <= ipPending[7:2];
        end
    end

    // Timer shares IP7 with the top hardware line
    assign ipPending = {hwSync2[5] | timerHit, hwSync2[4:0], swIp};

    assign intReq = status.ie && !status.exl && !status.erl &&
                    (|({hwIp, swIp} & status.im));

endmodule

`default_nettype wire

//--- design/cp0RegFile.sv
`timescale 1ns/100ps
`default_nettype none

module cp0RegFile (
    input  logic                   clk,
    input  logic                   rst,
    input  cp0RegPkg::cp0WrReq_t   wrReq,
    input  logic                   dropWrite,
    input  cp0ExcPkg::excUpdate_t  excUpd,
    input  logic [7:0]             ipPending,
    input  logic                   timerHit,
    input  logic [31:0]            count,
    input  logic [31:0]            compare,
    input  cp0RegPkg::regAddr_t    rdAddr,
    input  cp0RegPkg::regSel_t     rdSel,
    output logic [31:0]            rdData,
    output cp0RegPkg::cp0Status_t  status,
    output logic                   bev,
    output logic [1:0]             swIp,
    output logic [31:0]            epc,
    output logic [31:0]            eBase
);

    logic [31:0] statusReg;
    logic [31:0] causeReg;
    logic [31:0] epcReg;
    logic [31:0] badVAddrReg;
    logic [31:0] eBaseReg;
    logic        wrEn;
    logic [31:0] causeWr;

    assign wrEn    = wrReq.en && !dropWrite;
    assign causeWr = (causeReg & ~cp0RegPkg::MASK_CAUSE) | (wrReq.data & cp0RegPkg::MASK_CAUSE);

    always_ff @(posedge clk) begin
        if (rst) begin
            statusReg <= cp0RegPkg::RST_STATUS;
            causeReg  <= '0;
            eBaseReg  <= cp0RegPkg::RST_EBASE;
        end else begin
            causeReg[15:8] <= ipPending; // IP1..0 loop back from swIp
            causeReg[30]   <= timerHit;  // TI
            if (excUpd.setExl) begin
                statusReg[1]   <= 1'b1;
                causeReg[31]   <= excUpd.bd;
                causeReg[6:2]  <= excUpd.code;
            end else if (excUpd.clrExl) begin
                statusReg[1] <= 1'b0;
            end else if (wrEn) begin
                case (wrReq.addr)
                    cp0RegPkg::ADDR_STATUS: begin
                        statusReg <= (statusReg & ~cp0RegPkg::MASK_STATUS) |
                                     (wrReq.data & cp0RegPkg::MASK_STATUS);
                    end
                    cp0RegPkg::ADDR_CAUSE: begin
                        causeReg[9:8]   <= causeWr[9:8];
                        causeReg[23:22] <= causeWr[23:22]; // IV, WP
                    end
                    cp0RegPkg::ADDR_PRID: begin
                        if (wrReq.sel == cp0RegPkg::SEL_EBASE) begin
                            eBaseReg <= (eBaseReg & ~cp0RegPkg::MASK_EBASE) |
                                        (wrReq.data & cp0RegPkg::MASK_EBASE);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excUpd.setExl) begin
            epcReg <= excUpd.epc;
        end else if (wrEn && wrReq.addr == cp0RegPkg::ADDR_EPC) begin
            epcReg <= (epcReg & ~cp0RegPkg::MASK_EPC) | (wrReq.data & cp0RegPkg::MASK_EPC);
        end
        if (excUpd.loadBadVAddr) begin
            badVAddrReg <= excUpd.badAddr; // Read-only to software
        end
    end

    always_comb begin
        case (rdAddr)
            cp0RegPkg::ADDR_BADVADDR: rdData = badVAddrReg;
            cp0RegPkg::ADDR_COUNT:    rdData = count;
            cp0RegPkg::ADDR_COMPARE:  rdData = compare;
            cp0RegPkg::ADDR_STATUS:   rdData = statusReg;
            cp0RegPkg::ADDR_CAUSE:    rdData = causeReg;
            cp0RegPkg::ADDR_EPC:      rdData = epcReg;
            cp0RegPkg::ADDR_PRID: begin
                case (rdSel)
                    cp0RegPkg::SEL_PRID:  rdData = cp0RegPkg::RST_PRID;
                    cp0RegPkg::SEL_EBASE: rdData = eBaseReg;
                    default:              rdData = '0;
                endcase
            end
            cp0RegPkg::ADDR_CONFIG: begin
                rdData = (rdSel == cp0RegPkg::SEL_CONFIG) ? cp0RegPkg::RST_CONFIG : '0;
            end
            default:                  rdData = '0; // TLB, watch, debug and the rest
        endcase
    end

    assign status.im  = statusReg[15:8];
    assign status.erl = statusReg[2];
    assign status.exl = statusReg[1];
    assign status.ie  = statusReg[0];
    assign bev        = statusReg[22];
    assign swIp       = causeReg[9:8];
    assign epc        = epcReg;
    assign eBase      = eBaseReg;

endmodule

`default_nettype wire

//--- design/cp0RegPkg.sv
`default_nettype none

package cp0RegPkg;

    typedef logic [4:0] regAddr_t;
    typedef logic [2:0] regSel_t;

    localparam regAddr_t ADDR_BADVADDR = 5'd8;
    localparam regAddr_t ADDR_COUNT    = 5'd9;
    localparam regAddr_t ADDR_COMPARE  = 5'd11;
    localparam regAddr_t ADDR_STATUS   = 5'd12;
    localparam regAddr_t ADDR_CAUSE    = 5'd13;
    localparam regAddr_t ADDR_EPC      = 5'd14;
    localparam regAddr_t ADDR_PRID     = 5'd15; // EBase at select 1
    localparam regAddr_t ADDR_CONFIG   = 5'd16;

    localparam regSel_t SEL_PRID   = 3'd0;
    localparam regSel_t SEL_EBASE  = 3'd1;
    localparam regSel_t SEL_CONFIG = 3'd0;

    // IE, EXL, ERL, IM7..0, BEV
    localparam logic [31:0] MASK_STATUS  = 32'h0040_FF07;
    // IV, WP, IP1..0
    localparam logic [31:0] MASK_CAUSE   = 32'h00C0_0300;
    localparam logic [31:0] MASK_EPC     = 32'hFFFF_FFFF;
    localparam logic [31:0] MASK_EBASE   = 32'h3FFF_F000; // Base bits 29..12
    localparam logic [31:0] MASK_COMPARE = 32'hFFFF_FFFF;

    localparam logic [31:0] RST_STATUS  = 32'h0040_0004; // BEV and ERL set
    localparam logic [31:0] RST_EBASE   = 32'h8000_0000;
    localparam logic [31:0] RST_PRID    = 32'h00FF_0001;
    localparam logic [31:0] RST_CONFIG  = 32'h0000_0003; // Kseg0 cacheable, no MMU

    typedef struct packed {
        logic        en;
        regAddr_t    addr;
        regSel_t     sel;
        logic [31:0] data;
    } cp0WrReq_t;

    typedef struct packed {
        logic [7:0] im;
        logic       erl;
        logic       exl;
        logic       ie;
    } cp0Status_t;

endpackage

`default_nettype wire

//--- design/cp0Timer.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Timer (
    input  logic                  clk,
    input  logic                  rst,
    input  cp0RegPkg::cp0WrReq_t  wrReq,
    input  logic                  dropWrite,
    output logic [31:0]           count,
    output logic [31:0]           compare,
    output logic                  timerHit
);

    logic phase;
    logic wrCount;
    logic wrCompare;

    assign wrCount   = wrReq.en && !dropWrite && (wrReq.addr == cp0RegPkg::ADDR_COUNT);
    assign wrCompare = wrReq.en && !dropWrite && (wrReq.addr == cp0RegPkg::ADDR_COMPARE);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= 1'b0;
            count    <= '0;
            compare  <= '1; // Keep the timer quiet until software arms it
            timerHit <= 1'b0;
        end else begin
            phase <= ~phase;
            if (wrCount) begin
                count <= wrReq.data;
            end else begin
                count <= count + {31'd0, phase}; // Half clock rate
            end
            if (wrCompare) begin
                compare  <= (compare & ~cp0RegPkg::MASK_COMPARE) |
                            (wrReq.data & cp0RegPkg::MASK_COMPARE);
                timerHit <= 1'b0;
            end else if (count == compare) begin
                timerHit <= 1'b1; // Sticky until Compare is rewritten
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cp0Top.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Top (
    input  logic                   clk,
    input  logic                   rst,
    input  cp0RegPkg::cp0WrReq_t   wrReq,
    input  cp0RegPkg::regAddr_t    rdAddr,
    input  cp0RegPkg::regSel_t     rdSel,
    output logic [31:0]            rdData,
    input  cp0ExcPkg::excReport_t  excIn,
    input  logic [5:0]             hwInt,
    output cp0ExcPkg::redirect_t   redirect,
    output logic                   intReq,
    output logic                   exl
);

    cp0ExcPkg::excUpdate_t excUpd;
    cp0RegPkg::cp0Status_t status;
    logic                  dropWrite;
    logic                  bev;
    logic [1:0]            swIp;
    logic [31:0]           epc;
    logic [31:0]           eBase;
    logic [31:0]           count;
    logic [31:0]           compare;
    logic                  timerHit;
    logic [7:0]            ipPending;

    assign exl = status.exl;

    cp0ExcCtrl u_excCtrl (
        .clk       (clk),
        .rst       (rst),
        .excIn     (excIn),
        .status    (status),
        .epc       (epc),
        .eBase     (eBase),
        .bev       (bev),
        .excUpd    (excUpd),
        .dropWrite (dropWrite),
        .redirect  (redirect)
    );

    cp0RegFile u_regFile (
        .clk       (clk),
        .rst       (rst),
        .wrReq     (wrReq),
        .dropWrite (dropWrite),
        .excUpd    (excUpd),
        .ipPending (ipPending),
        .timerHit  (timerHit),
        .count     (count),
        .compare   (compare),
        .rdAddr    (rdAddr),
        .rdSel     (rdSel),
        .rdData    (rdData),
        .status    (status),
        .bev       (bev),
        .swIp      (swIp),
        .epc       (epc),
        .eBase     (eBase)
    );

    cp0Timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .wrReq     (wrReq),
        .dropWrite (dropWrite),
        .count     (count),
        .compare   (compare),
        .timerHit  (timerHit)
    );

    cp0IntrUnit u_intr (
        .clk       (clk),
        .rst       (rst),
        .hwInt     (hwInt),
        .swIp      (swIp),
        .timerHit  (timerHit),
        .status    (status),
        .ipPending (ipPending),
        .intReq    (intReq)
    );

endmodule

`default_nettype wire

//--- sim.f
design/cp0RegPkg.sv
design/cp0ExcPkg.sv
design/cp0ExcCtrl.sv
design/cp0RegFile.sv
design/cp0Timer.sv
design/cp0IntrUnit.sv
design/cp0Top.sv
sim/cp0Top_checker.sv
sim/cp0Tb.sv

//--- sim/cp0Tb.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Tb;

    logic                  clk;
    logic                  rst;
    cp0RegPkg::cp0WrReq_t  wrReq;
    cp0RegPkg::regAddr_t   rdAddr;
    cp0RegPkg::regSel_t    rdSel;
    logic [31:0]           rdData;
    cp0ExcPkg::excReport_t excIn;
    logic [5:0]            hwInt;
    cp0ExcPkg::redirect_t  redirect;
    logic                  intReq;
    logic                  exl;

    cp0Top u_dut (
        .clk      (clk),
        .rst      (rst),
        .wrReq    (wrReq),
        .rdAddr   (rdAddr),
        .rdSel    (rdSel),
        .rdData   (rdData),
        .excIn    (excIn),
        .hwInt    (hwInt),
        .redirect (redirect),
        .intReq   (intReq),
        .exl      (exl)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            failRun($sformatf("[ERROR] %s: expected %08h, actual %08h", name, exp, act));
        end
    endtask

    task automatic checkStatus(input string name, input cp0RegPkg::cp0Status_t exp,
                               input cp0RegPkg::cp0Status_t act);
        string expStr;
        string actStr;
        if (act !== exp) begin
            expStr = $sformatf("im=%02h erl=%b exl=%b ie=%b", exp.im, exp.erl, exp.exl, exp.ie);
            actStr = $sformatf("im=%02h erl=%b exl=%b ie=%b", act.im, act.erl, act.exl, act.ie);
            failRun($sformatf("[ERROR] %s: expected %s, actual %s", name, expStr, actStr));
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            failRun($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic writeReg(input cp0RegPkg::regAddr_t addr, input cp0RegPkg::regSel_t sel,
                            input logic [31:0] data);
        @(posedge clk);
        wrReq <= '{en: 1'b1, addr: addr, sel: sel, data: data};
        @(posedge clk);
        wrReq.en <= 1'b0; // Write lands on this edge
    endtask

    task automatic readReg(input cp0RegPkg::regAddr_t addr, input cp0RegPkg::regSel_t sel,
                           output logic [31:0] value);
        @(posedge clk);
        rdAddr <= addr;
        rdSel  <= sel;
        @(negedge clk);
        value = rdData;
    endtask

    task automatic maskedWrite(input string name, input cp0RegPkg::regAddr_t addr,
                               input cp0RegPkg::regSel_t sel, input logic [31:0] mask);
        logic [31:0] oldVal;
        logic [31:0] newData;
        logic [31:0] gotVal;
        readReg(addr, sel, oldVal);
        newData = $urandom();
        writeReg(addr, sel, newData);
        readReg(addr, sel, gotVal);
        checkWord(name, (oldVal & ~mask) | (newData & mask), gotVal);
    endtask

    task automatic waitIntReq(input string name, input logic exp, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (intReq !== exp) begin
            cycles++;
            if (cycles > limit) begin
                failRun($sformatf("%s: intReq did not reach %b within %0d cycles",
                                  name, exp, limit));
            end
            @(negedge clk);
        end
    endtask

    task automatic runExc(input string name, input logic [2:0] kind, input logic [31:0] pc,
                          input logic ds, input logic [31:0] bad, input logic [31:0] expTarget);
        cp0ExcPkg::excReport_t rep;
        int                    cycles;
        rep.valid     = 1'b1;
        rep.kind      = cp0ExcPkg::excKind_t'(kind);
        rep.pc        = pc;
        rep.delaySlot = ds;
        rep.badAddr   = bad;
        @(posedge clk);
        excIn <= rep;
        @(posedge clk);
        excIn.valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!redirect.valid) begin
            cycles++;
            if (cycles > 10) begin
                failRun($sformatf("%s: no redirect within 10 cycles of the exception", name));
            end
            @(negedge clk);
        end
        checkWord(name, expTarget, redirect.target);
        checkBit(name, rep.kind != cp0ExcPkg::KIND_ERET, exl); // Only Eret leaves EXL clear
    endtask

    task automatic runStatus(input string name, input logic [31:0] im, input logic erl,
                             input logic exlExp, input logic ie);
        cp0RegPkg::cp0Status_t expVal;
        cp0RegPkg::cp0Status_t actVal;
        logic [31:0]           raw;
        readReg(cp0RegPkg::ADDR_STATUS, 3'd0, raw);
        expVal = '{im: im[7:0], erl: erl, exl: exlExp, ie: ie};
        actVal = '{im: raw[15:8], erl: raw[2], exl: raw[1], ie: raw[0]};
        checkStatus(name, expVal, actVal);
    endtask

    task automatic runTimer(input string name, input logic [31:0] start,
                            input logic [31:0] lo, input logic [31:0] hi);
        writeReg(cp0RegPkg::ADDR_COUNT, 3'd0, start);
        writeReg(cp0RegPkg::ADDR_COMPARE, 3'd0, start + 32'd4);
        @(posedge clk);
        rdAddr <= cp0RegPkg::ADDR_COUNT;
        rdSel  <= 3'd0;
        waitIntReq(name, 1'b1, 40);
        if (rdData < lo || rdData > hi) begin
            failRun($sformatf("[ERROR] %s: expected Count in %08h..%08h, actual %08h",
                              name, lo, hi, rdData));
        end
        writeReg(cp0RegPkg::ADDR_COMPARE, 3'd0, start); // Rearm clears the hit
        waitIntReq(name, 1'b0, 10);
    endtask

    initial begin
        int          fd;
        int          n;
        string       name;
        string       op;
        string       line;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] value;
        void'($urandom(46235));
        rst    = 1'b1;
        wrReq  = '0;
        rdAddr = '0;
        rdSel  = '0;
        excIn  = '0;
        hwInt  = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("sim/cp0Tests.txt", "r");
        if (fd == 0) begin
            failRun("could not open the tests file sim/cp0Tests.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", name);
            if (n != 1) begin
                break;
            end
            if (name.getc(0) == "#") begin
                n = $fgets(line, fd);
            end else begin
                n = $fscanf(fd, "%s %h %h %h %h %h", op, a0, a1, a2, a3, a4);
                if (n != 6) begin
                    failRun($sformatf("test %s has a malformed line in the tests file", name));
                end
                case (op)
                    "read": begin
                        readReg(a0[4:0], a1[2:0], value);
                        checkWord(name, a2, value);
                    end
                    "write":  writeReg(a0[4:0], a1[2:0], a2);
                    "wrand":  maskedWrite(name, a0[4:0], a1[2:0], a2);
                    "exc":    runExc(name, a0[2:0], a1, a2[0], a3, a4);
                    "status": runStatus(name, a0, a1[0], a2[0], a3[0]);
                    "intr": begin
                        @(posedge clk);
                        hwInt <= a0[5:0];
                        waitIntReq(name, a1[0], 20);
                    end
                    "exl": begin
                        @(negedge clk);
                        checkBit(name, a0[0], exl);
                    end
                    "timer":  runTimer(name, a0, a1, a2);
                    default:  failRun($sformatf("test %s uses unknown operation %s", name, op));
                endcase
            end
        end
        $fclose(fd);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/cp0Tests.txt
# columns: name op a b c d e, operands in hex, unused ones are 0
# read/write/wrand: addr sel value-or-mask | exc: kind pc ds badAddr target | intr: hwInt intReq
rstStatusRaw read 0c 0 00400004 0 0
rstStatus status 00 1 0 0 0
rstPrid read 0f 0 00ff0001 0 0
rstEbase read 0f 1 80000000 0 0
rndStatus wrand 0c 0 0040ff07 0 0
rndEbase wrand 0f 1 3ffff000 0 0
rndCause wrand 0d 0 00c00300 0 0
clrCause write 0d 0 00000000 0 0
setEbase write 0f 1 00010000 0 0
clrStatus write 0c 0 00000000 0 0
readEbase read 0f 1 80010000 0 0
excOv exc 6 80001004 1 00000000 80010180
epcOv read 0e 0 80001000 0 0
causeOv read 0d 0 80000030 0 0
excNested exc 3 80002000 0 00000000 80010180
epcNested read 0e 0 80001000 0 0
eretOv exc 7 00000000 0 00000000 80001000
excAdel exc 1 80003008 0 1234567b 80010180
badvAdel read 08 0 1234567b 0 0
causeAdel read 0d 0 00000010 0 0
epcAdel read 0e 0 80003008 0 0
eretAdel exc 7 00000000 0 00000000 80003008
enInt write 0c 0 0000ff01 0 0
statusEn status ff 0 0 1 0
swIpSet write 0d 0 00000100 0 0
swIpReq intr 00 1 0 0 0
swIpClr write 0d 0 00000000 0 0
swIpDrop intr 00 0 0 0 0
hwReq intr 04 1 0 0 0
setExl write 0c 0 0000ff03 0 0
exlMask intr 04 0 0 0 0
exlBit exl 1 0 0 0 0
clrExl write 0c 0 0000ff01 0 0
hwAgain intr 04 1 0 0 0
hwDrop intr 00 0 0 0 0
timerMatch timer 00001000 00001004 00001006 0 0

//--- sim/cp0Top_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cp0Top_checker (
    input logic                  clk,
    input logic                  rst,
    input cp0ExcPkg::excReport_t excIn,
    input cp0ExcPkg::redirect_t  redirect,
    input cp0RegPkg::cp0Status_t status,
    input logic                  intReq
);

    redirectSingle: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !redirect.valid)
        else $error("redirect valid held for two cycles in a row");

    intReqMasked: assert property (@(posedge clk) disable iff (rst)
        !(intReq && (status.exl || status.erl)))
        else $error("interrupt request raised while EXL or ERL is set");

    // One cycle from report to redirect, in both directions
    redirectAfterExc: assert property (@(posedge clk) disable iff (rst)
        excIn.valid |=> redirect.valid)
        else $error("exception report not followed by a redirect");

    redirectHasExc: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> $past(excIn.valid))
        else $error("redirect without an exception report one cycle earlier");

endmodule

bind cp0Top cp0Top_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .excIn    (excIn),
    .redirect (redirect),
    .status   (status),
    .intReq   (intReq)
);

`default_nettype wire
